// File: flist.f
hdl/mem_tile_pkg.sv
hdl/mem_bus_if.sv
hdl/wb_mem_port.sv
hdl/mem_atop_resolver.sv
hdl/sram_macro.sv
hdl/sram_bank_array.sv
hdl/mem_tile.sv
tests/mem_tile_chk.sv
tests/tb_mem_tile.sv

// File: hdl/mem_atop_resolver.sv
// Resolves atomics into plain reads and writes, one sequence at a time.
// Expects a manager with at most one request in flight.
// A single reservation is kept; MAX compares signed full words.

`timescale 1ns/1ns
`default_nettype none

module mem_atop_resolver #(
  parameter int unsigned DataWidth    = mem_tile_pkg::DataWidth,
  parameter int unsigned NumBankRows  = mem_tile_pkg::NumBankRows,
  parameter int unsigned SramNumWords = mem_tile_pkg::SramNumWords
) (
  input  logic         clk_i,
  input  logic         arst_n_i,
  mem_bus_if.sbr       sbr_i,
  mem_bus_if.mgr_plain mgr_o
);
  import mem_tile_pkg::*;

  localparam int unsigned AddrWidth = $clog2(NumBankRows * SramNumWords);

  typedef enum logic [2:0] {S_IDLE, S_RD, S_WR, S_WRSP, S_RSP} state_e;

  state_e                 state_q;
  logic                   resv_valid_q;
  logic [AddrWidth-1:0]   resv_addr_q;
  atop_e                  op_q;
  logic [AddrWidth-1:0]   addr_q;
  logic [DataWidth-1:0]   wdata_q;
  logic [DataWidth/8-1:0] be_q;
  logic [DataWidth-1:0]   old_q;
  logic [DataWidth-1:0]   amo_res;
  logic                   resv_hit;
  logic                   sc_fail;
  logic                   accept;

  assign resv_hit = resv_valid_q && (resv_addr_q == sbr_i.addr);
  assign sc_fail  = (sbr_i.atop == SC) && !resv_hit;
  assign accept   = (state_q == S_IDLE) && sbr_i.req && sbr_i.gnt;

  // New word for the write phase
  always_comb begin
    case (op_q)
      ADD:     amo_res = old_q + wdata_q;
      AND:     amo_res = old_q & wdata_q;
      OR:      amo_res = old_q | wdata_q;
      MAX:     amo_res = ($signed(old_q) > $signed(wdata_q)) ? old_q : wdata_q;
      default: amo_res = wdata_q;
    endcase
  end

  ////////////////////////////////////////
  // Bus steering
  ////////////////////////////////////////

  always_comb begin
    mgr_o.req    = 1'b0;
    mgr_o.we     = 1'b0;
    mgr_o.addr   = sbr_i.addr;
    mgr_o.wdata  = sbr_i.wdata;
    mgr_o.be     = sbr_i.be;
    sbr_i.gnt    = 1'b0;
    sbr_i.rvalid = 1'b0;
    sbr_i.rdata  = mgr_o.rdata;
    case (state_q)
      S_IDLE: begin
        sbr_i.rvalid = mgr_o.rvalid;
        if (sc_fail) begin
          // Answered locally, memory untouched
          sbr_i.gnt = 1'b1;
        end else begin
          mgr_o.req = sbr_i.req;
          sbr_i.gnt = mgr_o.gnt;
          case (sbr_i.atop)
            NONE:    mgr_o.we = sbr_i.we;
            SC:      mgr_o.we = 1'b1;
            default: mgr_o.we = 1'b0;
          endcase
        end
      end
      S_WR: begin
        mgr_o.req   = 1'b1;
        mgr_o.we    = 1'b1;
        mgr_o.addr  = addr_q;
        mgr_o.wdata = amo_res;
        mgr_o.be    = be_q;
      end
      S_WRSP: begin
        sbr_i.rvalid = mgr_o.rvalid;
        sbr_i.rdata  = old_q;
      end
      S_RSP: begin
        sbr_i.rvalid = 1'b1;
        sbr_i.rdata  = old_q;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // Sequencer and reservation
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= S_IDLE;
      resv_valid_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (accept) begin
            case (sbr_i.atop)
              NONE: if (sbr_i.we && resv_hit) resv_valid_q <= 1'b0;
              LR:   resv_valid_q <= 1'b1;
              SC: begin
                resv_valid_q <= 1'b0;
                state_q      <= sc_fail ? S_RSP : S_WRSP;
              end
              default: state_q <= S_RD;
            endcase
          end
        end
        S_RD: if (mgr_o.rvalid) state_q <= S_WR;
        S_WR: begin
          if (mgr_o.gnt) begin
            state_q <= S_WRSP;
            if (resv_valid_q && resv_addr_q == addr_q) resv_valid_q <= 1'b0;
          end
        end
        S_WRSP:  if (mgr_o.rvalid) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q    <= sbr_i.atop;
      addr_q  <= sbr_i.addr;
      wdata_q <= sbr_i.wdata;
      be_q    <= sbr_i.be;
      // SC status word, overwritten by the read of an RMW
      old_q   <= sc_fail ? DataWidth'(1) : '0;
      if (sbr_i.atop == LR) resv_addr_q <= sbr_i.addr;
    end
    if (state_q == S_RD && mgr_o.rvalid) begin
      old_q <= mgr_o.rdata;
    end
  end

endmodule

`default_nettype wire

// File: hdl/mem_bus_if.sv
// Internal request/response link with a req/gnt handshake.
// One rvalid per granted request, in order, at least one cycle later.
// The plain modports leave atop out.

`timescale 1ns/1ns
`default_nettype none

interface mem_bus_if #(
  parameter int unsigned DataWidth = mem_tile_pkg::DataWidth,
  parameter int unsigned AddrWidth = $clog2(mem_tile_pkg::NumBankRows *
                                            mem_tile_pkg::SramNumWords)
);
  import mem_tile_pkg::*;

  logic                   req;
  logic                   gnt;
  logic                   we;
  logic [AddrWidth-1:0]   addr;
  logic [DataWidth-1:0]   wdata;
  logic [DataWidth/8-1:0] be;
  atop_e                  atop;
  logic                   rvalid;
  logic [DataWidth-1:0]   rdata;

  modport mgr (output req, we, addr, wdata, be, atop, input gnt, rvalid, rdata);
  modport sbr (input req, we, addr, wdata, be, atop, output gnt, rvalid, rdata);

  modport mgr_plain (output req, we, addr, wdata, be, input gnt, rvalid, rdata);
  modport sbr_plain (input req, we, addr, wdata, be, output gnt, rvalid, rdata);

endinterface

`default_nettype wire

// File: hdl/mem_tile.sv
// Memory tile, Wishbone classic slave in front of banked SRAM with atomics.
// adr_i is a word address; tga_i carries the atomic operation.
// Single outstanding cycle, no bursts, no error response.

`timescale 1ns/1ns
`default_nettype none

module mem_tile #(
  parameter int unsigned DataWidth       = mem_tile_pkg::DataWidth,
  parameter int unsigned NumBanksPerWord = mem_tile_pkg::NumBanksPerWord,
  parameter int unsigned NumBankRows     = mem_tile_pkg::NumBankRows,
  parameter int unsigned SramNumWords    = mem_tile_pkg::SramNumWords,
  localparam int unsigned AddrWidth      = $clog2(NumBankRows * SramNumWords)
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  input  logic                   we_i,
  input  logic [AddrWidth-1:0]   adr_i,
  input  logic [DataWidth-1:0]   dat_i,
  input  logic [DataWidth/8-1:0] sel_i,
  input  mem_tile_pkg::atop_e    tga_i,
  output logic [DataWidth-1:0]   dat_o,
  output logic                   ack_o
);

  mem_bus_if #(.DataWidth(DataWidth), .AddrWidth(AddrWidth)) bus_atop ();
  mem_bus_if #(.DataWidth(DataWidth), .AddrWidth(AddrWidth)) bus_mem ();

  ////////////////////////////////////////
  // Bus port
  ////////////////////////////////////////

  wb_mem_port #(
    .DataWidth   (DataWidth),
    .NumBankRows (NumBankRows),
    .SramNumWords(SramNumWords)
  ) u_port (
    .clk_i,
    .arst_n_i,
    .cyc_i,
    .stb_i,
    .we_i,
    .adr_i,
    .dat_i,
    .sel_i,
    .tga_i,
    .dat_o,
    .ack_o,
    .bus_o(bus_atop)
  );

  // Atomics between port and storage
  mem_atop_resolver #(
    .DataWidth   (DataWidth),
    .NumBankRows (NumBankRows),
    .SramNumWords(SramNumWords)
  ) u_resolver (
    .clk_i,
    .arst_n_i,
    .sbr_i(bus_atop),
    .mgr_o(bus_mem)
  );

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  sram_bank_array #(
    .DataWidth      (DataWidth),
    .NumBanksPerWord(NumBanksPerWord),
    .NumBankRows    (NumBankRows),
    .SramNumWords   (SramNumWords)
  ) u_banks (
    .clk_i,
    .arst_n_i,
    .bus_i(bus_mem)
  );

endmodule

`default_nettype wire

// File: hdl/mem_tile_pkg.sv
// Shared definitions for the memory tile.
// atop_e travels in the Wishbone address tag; geometry values are defaults only,
// the top level passes its own values down. DataWidth must be a multiple of
// 8 * NumBanksPerWord.

`default_nettype none

package mem_tile_pkg;

  ////////////////////////////////////////
  // Atomic operation codes
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    NONE = 3'd0,
    LR   = 3'd1,
    SC   = 3'd2,
    SWAP = 3'd3,
    ADD  = 3'd4,
    AND  = 3'd5,
    OR   = 3'd6,
    MAX  = 3'd7
  } atop_e;

  ////////////////////////////////////////
  // Default geometry
  ////////////////////////////////////////

  // Word width seen on the bus
  parameter int unsigned DataWidth = 32;

  // Banks side by side in one word
  parameter int unsigned NumBanksPerWord = 2;

  // Macro rows stacked in each bank
  parameter int unsigned NumBankRows = 2;

  // Words per macro
  parameter int unsigned SramNumWords = 64;

endpackage

`default_nettype wire

// File: hdl/sram_bank_array.sv
// Word storage built from NumBanksPerWord x NumBankRows single-port macros.
// Always grants; rvalid follows every granted request by exactly one cycle.
// DataWidth / NumBanksPerWord must be a multiple of 8.

`timescale 1ns/1ns
`default_nettype none

module sram_bank_array #(
  parameter int unsigned DataWidth       = mem_tile_pkg::DataWidth,
  parameter int unsigned NumBanksPerWord = mem_tile_pkg::NumBanksPerWord,
  parameter int unsigned NumBankRows     = mem_tile_pkg::NumBankRows,
  parameter int unsigned SramNumWords    = mem_tile_pkg::SramNumWords
) (
  input  logic         clk_i,
  input  logic         arst_n_i,
  mem_bus_if.sbr_plain bus_i
);

  localparam int unsigned SramAddrWidth = $clog2(SramNumWords);
  localparam int unsigned RowSelWidth   = (NumBankRows > 1) ? $clog2(NumBankRows) : 1;
  localparam int unsigned BankWidth     = DataWidth / NumBanksPerWord;

  logic [SramAddrWidth-1:0]                            sram_addr;
  logic [RowSelWidth-1:0]                              row_sel;
  logic [RowSelWidth-1:0]                              row_sel_q;
  logic                                                rvalid_q;
  logic [NumBankRows-1:0][NumBanksPerWord-1:0][BankWidth-1:0] rdata_split;
  logic [NumBanksPerWord-1:0][BankWidth-1:0]           rdata_word;

  // Low bits index the macro, upper bits pick the row
  assign sram_addr = bus_i.addr[SramAddrWidth-1:0];
  assign row_sel   = RowSelWidth'(bus_i.addr >> SramAddrWidth);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      row_sel_q <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req && bus_i.gnt;
      // Row of the pending read, used when its data comes back
      if (bus_i.req && !bus_i.we) row_sel_q <= row_sel;
    end
  end

  ////////////////////////////////////////
  // Macro grid
  ////////////////////////////////////////

  for (genvar i = 0; i < NumBanksPerWord; i++) begin : gen_banks
    for (genvar j = 0; j < NumBankRows; j++) begin : gen_rows
      sram_macro #(
        .NumWords (SramNumWords),
        .DataWidth(BankWidth)
      ) u_macro (
        .clk_i,
        .req_i  (bus_i.req && (row_sel == RowSelWidth'(j))),
        .we_i   (bus_i.we),
        .addr_i (sram_addr),
        .wdata_i(bus_i.wdata[i*BankWidth +: BankWidth]),
        .be_i   (bus_i.be[i*(BankWidth/8) +: BankWidth/8]),
        .rdata_o(rdata_split[j][i])
      );
    end
    assign rdata_word[i] = rdata_split[row_sel_q][i];
  end

  assign bus_i.gnt    = 1'b1;
  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_word;

endmodule

`default_nettype wire

// File: hdl/sram_macro.sv
// Single-port SRAM model, byte enables, one cycle read latency.
// Contents and read register power up undefined.

`timescale 1ns/1ns
`default_nettype none

module sram_macro #(
  parameter int unsigned NumWords   = 64,
  parameter int unsigned DataWidth  = 16,
  localparam int unsigned AddrWidth = $clog2(NumWords)
) (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [AddrWidth-1:0]   addr_i,
  input  logic [DataWidth-1:0]   wdata_i,
  input  logic [DataWidth/8-1:0] be_i,
  output logic [DataWidth-1:0]   rdata_o
);

  logic [DataWidth-1:0] mem_q [NumWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < DataWidth / 8; b++) begin
          if (be_i[b]) mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/wb_mem_port.sv
// Wishbone classic slave, word addressed, one transaction in flight.
// The master must hold all inputs until ack_o; a held strobe after ack_o
// is not taken again. dat_o is only meaningful while ack_o is high.

`timescale 1ns/1ns
`default_nettype none

module wb_mem_port #(
  parameter int unsigned DataWidth    = mem_tile_pkg::DataWidth,
  parameter int unsigned NumBankRows  = mem_tile_pkg::NumBankRows,
  parameter int unsigned SramNumWords = mem_tile_pkg::SramNumWords,
  localparam int unsigned AddrWidth   = $clog2(NumBankRows * SramNumWords)
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  input  logic                   we_i,
  input  logic [AddrWidth-1:0]   adr_i,
  input  logic [DataWidth-1:0]   dat_i,
  input  logic [DataWidth/8-1:0] sel_i,
  input  mem_tile_pkg::atop_e    tga_i,
  output logic [DataWidth-1:0]   dat_o,
  output logic                   ack_o,
  mem_bus_if.mgr                 bus_o
);
  import mem_tile_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_ACK} state_e;

  state_e                 state_q;
  logic                   ack_q;
  logic                   we_q;
  logic [AddrWidth-1:0]   addr_q;
  logic [DataWidth-1:0]   wdata_q;
  logic [DataWidth/8-1:0] be_q;
  atop_e                  atop_q;
  logic [DataWidth-1:0]   dat_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      ack_q   <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      case (state_q)
        S_IDLE: if (cyc_i && stb_i) state_q <= S_REQ;
        S_REQ:  if (bus_o.gnt) state_q <= S_WAIT;
        S_WAIT: begin
          if (bus_o.rvalid) begin
            state_q <= S_ACK;
            ack_q   <= 1'b1;
          end
        end
        // Hold here until the strobe of the finished cycle drops
        S_ACK:   if (!(cyc_i && stb_i)) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && cyc_i && stb_i) begin
      we_q    <= we_i;
      addr_q  <= adr_i;
      wdata_q <= dat_i;
      be_q    <= sel_i;
      atop_q  <= tga_i;
    end
    if (state_q == S_WAIT && bus_o.rvalid) begin
      dat_q <= bus_o.rdata;
    end
  end

  assign bus_o.req   = (state_q == S_REQ);
  assign bus_o.we    = we_q;
  assign bus_o.addr  = addr_q;
  assign bus_o.wdata = wdata_q;
  assign bus_o.be    = be_q;
  assign bus_o.atop  = atop_q;

  assign dat_o = dat_q;
  assign ack_o = ack_q;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Compile and run the mem_tile testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_mem_tile \
  -f flist.f --Mdir obj_dir -o tb_mem_tile
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_mem_tile > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  exit 1
fi
if ! grep -q "No errors" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// File: tests/mem_tile_chk.sv
// Wishbone handshake properties on the tile boundary, bound into mem_tile.
// Sampled on the rising clock edge.

`timescale 1ns/1ns
`default_nettype none

module mem_tile_chk (
  input logic clk_i,
  input logic arst_n_i,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i
);

  int fail_count = 0;

  // Ack only inside an active cycle
  ack_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(ack_i) |-> (cyc_i && stb_i))
    else begin
      fail_count++;
      $error("ack_o rose outside an active bus cycle");
    end

  // Single cycle pulse
  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_i |=> !ack_i)
    else begin
      fail_count++;
      $error("ack_o held high for two cycles");
    end

  ack_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !ack_i)
    else begin
      fail_count++;
      $error("ack_o high while reset is asserted");
    end

endmodule

bind mem_tile mem_tile_chk i_chk (
  .clk_i   (clk_i),
  .arst_n_i(arst_n_i),
  .cyc_i   (cyc_i),
  .stb_i   (stb_i),
  .ack_i   (ack_o)
);

`default_nettype wire

// File: tests/tb_mem_tile.sv
// Testbench for mem_tile with the default geometry (128 words of 32 bits).
// Expected results come from a reference memory and reservation, built with the table.
// Random checks use a fixed pool of addresses, so no unwritten word is ever compared.

`timescale 1ns/1ns
`default_nettype none

module tb_mem_tile;
  import mem_tile_pkg::*;

  localparam int unsigned NumWords  = NumBankRows * SramNumWords;
  localparam int unsigned AddrWidth = $clog2(NumWords);
  localparam int unsigned NumRandom = 64;

  typedef struct {
    logic                   we;
    logic [AddrWidth-1:0]   addr;
    logic [DataWidth-1:0]   data;
    logic [DataWidth/8-1:0] sel;
    atop_e                  atop;
    logic                   check;
    logic [DataWidth-1:0]   exp;
  } entry_t;

  logic                   clk;
  logic                   arst_n_i;
  logic                   cyc_i;
  logic                   stb_i;
  logic                   we_i;
  logic [AddrWidth-1:0]   adr_i;
  logic [DataWidth-1:0]   dat_i;
  logic [DataWidth/8-1:0] sel_i;
  atop_e                  tga_i;
  logic [DataWidth-1:0]   dat_o;
  logic                   ack_o;

  entry_t               table_q[$];
  logic [DataWidth-1:0] ref_mem [NumWords];
  logic                 ref_resv_valid = 1'b0;
  logic [AddrWidth-1:0] ref_resv_addr = '0;
  logic [31:0]          lcg_state = 32'h37228f14;
  int                   pool [8];
  int                   errors = 0;
  int                   checks = 0;
  int                   cycles = 0;
  int                   timeout_limit = 0;

  mem_tile i_dut (
    .clk_i   (clk),
    .arst_n_i(arst_n_i),
    .cyc_i   (cyc_i),
    .stb_i   (stb_i),
    .we_i    (we_i),
    .adr_i   (adr_i),
    .dat_i   (dat_i),
    .sel_i   (sel_i),
    .tga_i   (tga_i),
    .dat_o   (dat_o),
    .ack_o   (ack_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [DataWidth-1:0] byte_mask(input logic [DataWidth/8-1:0] sel);
    logic [DataWidth-1:0] m;
    for (int b = 0; b < DataWidth / 8; b++) m[b*8 +: 8] = {8{sel[b]}};
    return m;
  endfunction

  function automatic logic [31:0] addr_pattern(input int a);
    return {8'hA5, a[7:0], ~a[7:0], 8'h3C};
  endfunction

  ////////////////////////////////////////
  // Reference model and table
  ////////////////////////////////////////

  // Steps the reference state and appends the entry with its expected dat_o
  task automatic add_op(input logic we, input int addr, input logic [DataWidth-1:0] data,
                        input logic [DataWidth/8-1:0] sel, input atop_e atop,
                        input logic check);
    entry_t               e;
    logic [AddrWidth-1:0] a;
    logic [DataWidth-1:0] old;
    logic [DataWidth-1:0] res;
    logic                 hit;
    logic                 do_write;
    a   = AddrWidth'(addr);
    old = ref_mem[a];
    hit = ref_resv_valid && (ref_resv_addr == a);
    case (atop)
      ADD:     res = old + data;
      AND:     res = old & data;
      OR:      res = old | data;
      MAX:     res = ($signed(old) > $signed(data)) ? old : data;
      default: res = data;
    endcase
    e = '{we: we, addr: a, data: data, sel: sel, atop: atop, check: check, exp: old};
    // Plain writes return nothing defined
    if (atop == NONE && we) e.check = 1'b0;
    if (atop == SC) e.exp = hit ? '0 : DataWidth'(1);
    do_write = (atop == NONE && we) || (atop inside {SWAP, ADD, AND, OR, MAX}) ||
               (atop == SC && hit);
    if (do_write) begin
      ref_mem[a] = (old & ~byte_mask(sel)) | (res & byte_mask(sel));
      if (hit) ref_resv_valid = 1'b0;
    end
    if (atop == LR) begin
      ref_resv_valid = 1'b1;
      ref_resv_addr  = a;
    end
    if (atop == SC) ref_resv_valid = 1'b0;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    atop_e                  op;
    logic                   rnd_we;
    logic [DataWidth/8-1:0] rnd_sel;
    // Rows alternate from one entry to the next
    pool = '{0, 64, 1, 65, 63, 127, 37, 100};
    // Partial byte writes merge into the stored word
    add_op(1'b1, 5, 32'h11223344, 4'hf, NONE, 1'b0);
    add_op(1'b1, 5, 32'hAABBCCDD, 4'b0101, NONE, 1'b0);
    add_op(1'b0, 5, 32'h0, 4'hf, NONE, 1'b1);
    add_op(1'b1, 70, 32'h0BADF00D, 4'hf, NONE, 1'b0);
    add_op(1'b1, 70, 32'hCAFE1234, 4'b1100, NONE, 1'b0);
    add_op(1'b0, 70, 32'h0, 4'hf, NONE, 1'b1);
    // First, last and row-boundary words
    foreach (pool[k]) add_op(1'b1, pool[k], addr_pattern(pool[k]), 4'hf, NONE, 1'b0);
    foreach (pool[k]) add_op(1'b0, pool[k], 32'h0, 4'hf, NONE, 1'b1);
    // Read-modify-write operations
    add_op(1'b1, 37, 32'h12345678, 4'hf, SWAP, 1'b1);
    add_op(1'b0, 37, 32'h0, 4'hf, NONE, 1'b1);
    add_op(1'b1, 37, 32'h00000F0F, 4'hf, ADD, 1'b1);
    add_op(1'b0, 37, 32'h0, 4'hf, NONE, 1'b1);
    add_op(1'b1, 37, 32'hFF00FF00, 4'hf, AND, 1'b1);
    add_op(1'b0, 37, 32'h0, 4'hf, NONE, 1'b1);
    add_op(1'b1, 37, 32'h000000AA, 4'hf, OR, 1'b1);
    add_op(1'b0, 37, 32'h0, 4'hf, NONE, 1'b1);
    add_op(1'b1, 100, 32'hFFFFFFF0, 4'hf, NONE, 1'b0);
    add_op(1'b1, 100, 32'h00000005, 4'hf, MAX, 1'b1);
    add_op(1'b0, 100, 32'h0, 4'hf, NONE, 1'b1);
    add_op(1'b1, 100, 32'h80000000, 4'hf, MAX, 1'b1);
    add_op(1'b0, 100, 32'h0, 4'hf, NONE, 1'b1);
    add_op(1'b1, 1, 32'h000001FF, 4'b0011, ADD, 1'b1);
    add_op(1'b0, 1, 32'h0, 4'hf, NONE, 1'b1);
    // Reservations
    add_op(1'b0, 64, 32'h0, 4'hf, LR, 1'b1);
    add_op(1'b1, 64, 32'hDEADBEEF, 4'hf, SC, 1'b1);
    add_op(1'b0, 64, 32'h0, 4'hf, NONE, 1'b1);
    add_op(1'b1, 64, 32'h01010101, 4'hf, SC, 1'b1);
    add_op(1'b0, 64, 32'h0, 4'hf, NONE, 1'b1);
    add_op(1'b0, 65, 32'h0, 4'hf, LR, 1'b1);
    add_op(1'b1, 65, 32'h5A5A5A5A, 4'hf, NONE, 1'b0);
    add_op(1'b1, 65, 32'h77777777, 4'hf, SC, 1'b1);
    add_op(1'b0, 65, 32'h0, 4'hf, NONE, 1'b1);
    add_op(1'b0, 63, 32'h0, 4'hf, LR, 1'b1);
    add_op(1'b1, 127, 32'h13572468, 4'hf, SC, 1'b1);
    add_op(1'b0, 127, 32'h0, 4'hf, NONE, 1'b1);
    add_op(1'b1, 63, 32'h24681357, 4'hf, SC, 1'b1);
    // Mixed random operations over the pool
    for (int n = 0; n < NumRandom; n++) begin
      lcg_state = lcg_next(lcg_state);
      op        = atop_e'(lcg_state[27:25]);
      rnd_we    = (op == NONE) ? lcg_state[24] : (op != LR);
      rnd_sel   = (lcg_state[23:20] == 4'h0) ? 4'hf : lcg_state[23:20];
      lcg_state = lcg_next(lcg_state);
      add_op(rnd_we, pool[lcg_state[31:29]], lcg_state, rnd_sel, op, 1'b1);
    end
  endtask

  ////////////////////////////////////////
  // Bus driver and run control
  ////////////////////////////////////////

  task automatic apply_entry(input entry_t e);
    logic [DataWidth-1:0] got;
    @(negedge clk);
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = e.we;
    adr_i = e.addr;
    dat_i = e.data;
    sel_i = e.sel;
    tga_i = e.atop;
    @(negedge clk);
    while (ack_o !== 1'b1) @(negedge clk);
    got = dat_o;
    // Strobe drops in the cycle after ack
    @(negedge clk);
    cyc_i = 1'b0;
    stb_i = 1'b0;
    if (e.check) begin
      checks++;
      assert (got === e.exp) else begin
        errors++;
        $display("CHECK FAILED dat_o addr=%h exp=%h got=%h", e.addr, e.exp, got);
      end
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (timeout_limit != 0 && cycles >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("Checks: %0d, errors: %0d", checks, errors + i_dut.i_chk.fail_count);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    arst_n_i = 1'b0;
    cyc_i    = 1'b0;
    stb_i    = 1'b0;
    we_i     = 1'b0;
    adr_i    = '0;
    dat_i    = '0;
    sel_i    = '0;
    tga_i    = NONE;
    build_table();
    timeout_limit = 20 * table_q.size() + NumRandom + 50;
    repeat (3) @(negedge clk);
    arst_n_i = 1'b1;
    // Quiet bus, no ack expected
    repeat (4) begin
      @(negedge clk);
      checks++;
      assert (ack_o === 1'b0) else begin
        errors++;
        $display("CHECK FAILED ack_o exp=0 got=%h", ack_o);
      end
    end
    foreach (table_q[i]) apply_entry(table_q[i]);
    repeat (2) @(negedge clk);
    // Handshake property failures from the bound checker
    errors += i_dut.i_chk.fail_count;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
